/* Makefile */
TOP := tb_analog_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

obj_dir/V$(TOP): verilog.f *.sv *.svh
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* adc_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rp_consts.svh"

module adc_frontend (
  input  wire logic                              adc_clk,
  input  wire logic                              rst_n_i,
  input  wire logic [1:0][`RP_ADC_W-1:0]         adc_dat_i,  // [0] is channel a
  input  wire logic                              loop_en_i,
  input  wire rp_pkg::sample_pair_t              dac_smp_i,  // Saturated DAC samples
  output rp_pkg::sample_pair_t                   smp_o
);

  logic [1:0][`RP_SMP_W-1:0] raw_q;   // Top bits of each ADC bus
  logic [1:0][`RP_SMP_W-1:0] cnv;     // Two's complement
  logic                      loop_q;  // Select aligned with raw_q

  // Input register, the 2 LSBs are dropped
  always_ff @(posedge adc_clk)
  begin
    raw_q[0] <= adc_dat_i[0][`RP_ADC_W-1 -: `RP_SMP_W];
    raw_q[1] <= adc_dat_i[1][`RP_ADC_W-1 -: `RP_SMP_W];
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      loop_q <= 1'b0;
    else
      loop_q <= loop_en_i;
  end

  // Negative slope offset binary to two's complement
  always_comb
  begin
    for (int i = 0; i < 2; i++)
      cnv[i] = {raw_q[i][`RP_SMP_W-1], ~raw_q[i][`RP_SMP_W-2:0]};
  end

  // Digital loop replaces the ADC with the DAC side
  assign smp_o = loop_q ? dac_smp_i : rp_pkg::sample_pair_t'({cnv[1], cnv[0]});

endmodule

`default_nettype wire

/* analog_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rp_consts.svh"

module analog_top (
  input  wire logic                        adc_clk,
  input  wire logic                        rst_n_i,
  input  wire logic [1:0][`RP_ADC_W-1:0]   adc_dat_i,   // [0] channel a
  input  wire rp_pkg::wb_req_t             wb_req_i,    // External host
  output rp_pkg::wb_rsp_t                  wb_rsp_o,
  output rp_pkg::dac_pair_t                dac_dat_o,
  output logic                             dac_wrt_o
);

  ////////////////////////////////////////////////////////////
  // Local signals
  ////////////////////////////////////////////////////////////

  rp_pkg::sample_pair_t adc_smp;     // Frontend to capture
  rp_pkg::sample_pair_t dac_smp;     // Saturated DAC side
  rp_pkg::sample_pair_t gen_smp;
  logic                 gen_vld;
  rp_pkg::ctrl_t        ctrl;
  rp_pkg::sample_t      ofs_a;
  rp_pkg::sample_t      ofs_b;
  logic                 cap_arm;
  logic                 cap_done;
  rp_pkg::wb_req_t      host_ram_req, cap_req, gen_req;
  rp_pkg::wb_rsp_t      host_ram_rsp, cap_rsp, gen_rsp;

  ////////////////////////////////////////////////////////////
  // Acquisition
  ////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk   (adc_clk     ),
    .rst_n_i   (rst_n_i     ),
    .adc_dat_i (adc_dat_i   ),
    .loop_en_i (ctrl.loop_en),
    .dac_smp_i (dac_smp     ),
    .smp_o     (adc_smp     )
  );

  capture_writer i_cap (
    .adc_clk    (adc_clk     ),
    .rst_n_i    (rst_n_i     ),
    .smp_i      (adc_smp     ),
    .cap_arm_i  (cap_arm     ),
    .cap_len_i  (ctrl.cap_len),
    .cap_done_o (cap_done    ),
    .mem_req_o  (cap_req     ),
    .mem_rsp_i  (cap_rsp     )
  );

  ////////////////////////////////////////////////////////////
  // Shared RAM and host
  ////////////////////////////////////////////////////////////

  sample_ram_arbiter i_arb (
    .adc_clk    (adc_clk     ),
    .rst_n_i    (rst_n_i     ),
    .host_req_i (host_ram_req),
    .cap_req_i  (cap_req     ),
    .gen_req_i  (gen_req     ),
    .host_rsp_o (host_ram_rsp),
    .cap_rsp_o  (cap_rsp     ),
    .gen_rsp_o  (gen_rsp     )
  );

  host_regs i_regs (
    .adc_clk    (adc_clk     ),
    .rst_n_i    (rst_n_i     ),
    .wb_req_i   (wb_req_i    ),
    .wb_rsp_o   (wb_rsp_o    ),
    .ram_req_o  (host_ram_req),
    .ram_rsp_i  (host_ram_rsp),
    .ctrl_o     (ctrl        ),
    .ofs_a_o    (ofs_a       ),
    .ofs_b_o    (ofs_b       ),
    .cap_arm_o  (cap_arm     ),
    .cap_done_i (cap_done    )
  );

  ////////////////////////////////////////////////////////////
  // Generation
  ////////////////////////////////////////////////////////////

  waveform_reader i_gen (
    .adc_clk   (adc_clk     ),
    .rst_n_i   (rst_n_i     ),
    .gen_en_i  (ctrl.gen_en ),
    .gen_len_i (ctrl.gen_len),
    .mem_req_o (gen_req     ),
    .mem_rsp_i (gen_rsp     ),
    .smp_o     (gen_smp     ),
    .smp_vld_o (gen_vld     )
  );

  dac_backend i_dac (
    .adc_clk   (adc_clk  ),
    .rst_n_i   (rst_n_i  ),
    .smp_i     (gen_smp  ),
    .smp_vld_i (gen_vld  ),
    .ofs_a_i   (ofs_a    ),
    .ofs_b_i   (ofs_b    ),
    .dac_smp_o (dac_smp  ),
    .dac_dat_o (dac_dat_o),
    .dac_wrt_o (dac_wrt_o)
  );

endmodule

`default_nettype wire

/* capture_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rp_consts.svh"

module capture_writer (
  input  wire logic                   adc_clk,
  input  wire logic                   rst_n_i,
  input  wire rp_pkg::sample_pair_t   smp_i,
  input  wire logic                   cap_arm_i,    // One cycle pulse
  input  wire logic [`RP_RAM_AW:0]    cap_len_i,
  output logic                        cap_done_o,
  output rp_pkg::wb_req_t             mem_req_o,
  input  wire rp_pkg::wb_rsp_t        mem_rsp_i
);

  localparam int PW = $clog2(`RP_DECIM);
  localparam int SW = `RP_SMP_W;
  localparam int HW = 16;             // Half RAM word per channel

  logic                  active_q;
  logic [PW-1:0]         pace_q;      // Phase within the decimation period
  logic [`RP_RAM_AW:0]   idx_q;       // Next sample number
  logic                  stb_q;       // Write pending
  logic [`RP_RAM_AW-1:0] adr_q;
  logic [31:0]           dat_q;
  logic                  take;

  assign take = active_q && pace_q == '0 && idx_q != cap_len_i;

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      active_q   <= 1'b0;
      cap_done_o <= 1'b0;
      pace_q     <= '0;
      idx_q      <= '0;
      stb_q      <= 1'b0;
    end
    else
    begin
      if (mem_rsp_i.ack)
        stb_q <= 1'b0;                // Write accepted
      if (cap_arm_i)
      begin
        active_q   <= 1'b1;           // Sample 0 is taken next cycle
        cap_done_o <= 1'b0;
        pace_q     <= '0;
        idx_q      <= '0;
      end
      else if (active_q)
      begin
        pace_q <= (pace_q == PW'(`RP_DECIM - 1)) ? '0 : pace_q + 1'b1;
        if (take)
        begin
          stb_q <= 1'b1;
          idx_q <= idx_q + 1'b1;
        end
        // Last write acked
        if (idx_q == cap_len_i && !stb_q)
        begin
          active_q   <= 1'b0;
          cap_done_o <= 1'b1;
        end
      end
    end
  end

  // Address and payload, each channel sign extended
  always_ff @(posedge adc_clk)
  begin
    if (take)
    begin
      adr_q <= idx_q[`RP_RAM_AW-1:0];
      dat_q <= {{(HW-SW){smp_i.b[SW-1]}}, smp_i.b, {(HW-SW){smp_i.a[SW-1]}}, smp_i.a};
    end
  end

  always_comb
  begin
    mem_req_o.cyc = stb_q;
    mem_req_o.stb = stb_q;
    mem_req_o.we  = 1'b1;
    mem_req_o.adr = {{(`RP_WB_AW-`RP_RAM_AW){1'b0}}, adr_q};
    mem_req_o.dat = dat_q;
  end

  // Arbiter latency must keep up with the pacing
  a_no_overrun: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    take |-> (!stb_q || mem_rsp_i.ack));

endmodule

`default_nettype wire

/* dac_backend.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rp_consts.svh"

module dac_backend (
  input  wire logic                  adc_clk,
  input  wire logic                  rst_n_i,
  input  wire rp_pkg::sample_pair_t  smp_i,
  input  wire logic                  smp_vld_i,
  input  wire rp_pkg::sample_t       ofs_a_i,
  input  wire rp_pkg::sample_t       ofs_b_i,
  output rp_pkg::sample_pair_t       dac_smp_o,    // Back to the digital loop
  output rp_pkg::dac_pair_t          dac_dat_o,
  output logic                       dac_wrt_o
);

  localparam int SW = `RP_SMP_W;

  rp_pkg::sample_pair_t sat;

  // 15-bit sum clipped to -8192..8191
  function automatic rp_pkg::sample_t sat_add(rp_pkg::sample_t x, rp_pkg::sample_t y);
    logic signed [SW:0] sum;
    sum = {x[SW-1], x} + {y[SW-1], y};
    if (sum[SW] != sum[SW-1])
      return {sum[SW], {(SW-1){~sum[SW]}}};   // Overflow, clip toward the sign
    return sum[SW-1:0];
  endfunction

  // Back to negative slope offset binary
  function automatic logic [SW-1:0] dac_code(rp_pkg::sample_t s);
    return {s[SW-1], ~s[SW-2:0]};
  endfunction

  always_comb
  begin
    sat.a = sat_add(smp_i.a, ofs_a_i);
    sat.b = sat_add(smp_i.b, ofs_b_i);
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_wrt_o   <= 1'b0;
      dac_dat_o.a <= dac_code('0);      // 0x1FFF, zero output
      dac_dat_o.b <= dac_code('0);
      dac_smp_o   <= '0;
    end
    else
    begin
      dac_wrt_o <= smp_vld_i;           // Strobe with the new code
      if (smp_vld_i)
      begin
        dac_smp_o   <= sat;
        dac_dat_o.a <= dac_code(sat.a);
        dac_dat_o.b <= dac_code(sat.b);
      end
    end
  end

endmodule

`default_nettype wire

/* host_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rp_consts.svh"

module host_regs (
  input  wire logic             adc_clk,
  input  wire logic             rst_n_i,
  input  wire rp_pkg::wb_req_t  wb_req_i,
  output rp_pkg::wb_rsp_t       wb_rsp_o,
  output rp_pkg::wb_req_t       ram_req_o,
  input  wire rp_pkg::wb_rsp_t  ram_rsp_i,
  output rp_pkg::ctrl_t         ctrl_o,
  output rp_pkg::sample_t       ofs_a_o,
  output rp_pkg::sample_t       ofs_b_o,
  output logic                  cap_arm_o,
  input  wire logic             cap_done_i
);

  logic                win;          // RAM window hit
  logic                reg_stb;
  logic                reg_wr;
  logic                reg_ack_q;
  logic [31:0]         reg_dat_q;
  logic [31:0]         rd_dat;
  logic                gen_q;
  logic                loop_q;
  logic [`RP_RAM_AW:0] cap_len_q;
  logic [`RP_RAM_AW:0] gen_len_q;

  assign win     = wb_req_i.adr >= `RP_RAM_BASE;
  assign reg_stb = wb_req_i.cyc && wb_req_i.stb && !win;
  assign reg_wr  = reg_stb && wb_req_i.we && !reg_ack_q;   // Once per access

  // Register read mux
  always_comb
  begin
    case (wb_req_i.adr)
      `RP_REG_CTRL:    rd_dat = {29'd0, loop_q, gen_q, 1'b0};   // Arm reads 0
      `RP_REG_STAT:    rd_dat = {31'd0, cap_done_i};
      `RP_REG_OFS_A:   rd_dat = 32'(ofs_a_o);                   // Sign extended
      `RP_REG_OFS_B:   rd_dat = 32'(ofs_b_o);
      `RP_REG_CAP_LEN: rd_dat = 32'(cap_len_q);
      `RP_REG_GEN_LEN: rd_dat = 32'(gen_len_q);
      default:         rd_dat = '0;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      reg_ack_q <= 1'b0;
      cap_arm_o <= 1'b0;
      gen_q     <= 1'b0;
      loop_q    <= 1'b0;
      ofs_a_o   <= '0;
      ofs_b_o   <= '0;
      cap_len_q <= '0;
      gen_len_q <= '0;
    end
    else
    begin
      reg_ack_q <= reg_stb && !reg_ack_q;   // Ack one cycle after stb
      cap_arm_o <= reg_wr && wb_req_i.adr == `RP_REG_CTRL && wb_req_i.dat[0];
      if (reg_wr)
      begin
        case (wb_req_i.adr)
          `RP_REG_CTRL:
          begin
            gen_q  <= wb_req_i.dat[1];
            loop_q <= wb_req_i.dat[2];
          end
          `RP_REG_OFS_A:   ofs_a_o   <= wb_req_i.dat[`RP_SMP_W-1:0];
          `RP_REG_OFS_B:   ofs_b_o   <= wb_req_i.dat[`RP_SMP_W-1:0];
          `RP_REG_CAP_LEN: cap_len_q <= wb_req_i.dat[`RP_RAM_AW:0];
          `RP_REG_GEN_LEN: gen_len_q <= wb_req_i.dat[`RP_RAM_AW:0];
          default:         ;
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    reg_dat_q <= rd_dat;
  end

  // RAM window passes through to the arbiter, word 0x200 is RAM word 0
  always_comb
  begin
    ram_req_o     = wb_req_i;
    ram_req_o.cyc = wb_req_i.cyc && win;
    ram_req_o.stb = wb_req_i.stb && win;
    ram_req_o.adr = wb_req_i.adr - `RP_RAM_BASE;
  end

  always_comb
  begin
    wb_rsp_o.ack = reg_ack_q | ram_rsp_i.ack;
    wb_rsp_o.dat = ram_rsp_i.ack ? ram_rsp_i.dat : reg_dat_q;
  end

  always_comb
  begin
    ctrl_o.loop_en = loop_q;
    ctrl_o.gen_en  = gen_q;
    ctrl_o.cap_len = cap_len_q;
    ctrl_o.gen_len = gen_len_q;
  end

  // Covers the arbiter path as well as the registers
  a_ack_has_stb: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb));

endmodule

`default_nettype wire

/* rp_consts.svh */
`ifndef RP_CONSTS_SVH
`define RP_CONSTS_SVH

// Data path widths
`define RP_ADC_W       16      // Raw ADC bus
`define RP_SMP_W       14      // Converted sample

// Shared sample RAM
`define RP_RAM_AW      8       // 256 words of 32 bits

// Capture and playback pacing in adc_clk cycles
`define RP_DECIM       4

// Host Wishbone word address width
`define RP_WB_AW       10

// Register word addresses
`define RP_REG_CTRL    10'h000 // arm, gen_en, loop_en
`define RP_REG_STAT    10'h001 // cap_done
`define RP_REG_OFS_A   10'h002
`define RP_REG_OFS_B   10'h003
`define RP_REG_CAP_LEN 10'h004
`define RP_REG_GEN_LEN 10'h005

`define RP_RAM_BASE    10'h200 // Start of RAM window

`endif

/* rp_pkg.sv */
`default_nettype none

`include "rp_consts.svh"

package rp_pkg;

  // Two's complement sample
  typedef logic signed [`RP_SMP_W-1:0] sample_t;

  // Channel b in the high half, as in a RAM word
  typedef struct packed {
    sample_t b;
    sample_t a;
  } sample_pair_t;

  // Wishbone classic request, held by the master until ack
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [`RP_WB_AW-1:0] adr;   // Word address
    logic [31:0]          dat;   // Write data
  } wb_req_t;

  typedef struct packed {
    logic        ack;            // One cycle per access
    logic [31:0] dat;            // Read data, valid with ack
  } wb_rsp_t;

  // Unsigned negative slope DAC codes
  typedef struct packed {
    logic [`RP_SMP_W-1:0] b;
    logic [`RP_SMP_W-1:0] a;
  } dac_pair_t;

  // Static configuration from the register block
  typedef struct packed {
    logic                 loop_en;
    logic                 gen_en;
    logic [`RP_RAM_AW:0]  cap_len;   // Up to a full RAM
    logic [`RP_RAM_AW:0]  gen_len;
  } ctrl_t;

endpackage

`default_nettype wire

/* rp_stim.txt */
// One 32-bit hex word per line, fixed positions
// 0 ofs_a, 1 ofs_b, 2 cap_len, 3 gen_len, 4 ramp seed a, 5 ramp seed b
// 6..9 waveform RAM words {b,a} sign extended halves
// 10..13 expected DAC codes, b in bits 29:16, a in bits 13:0

// Offsets, +256 and -256
00000100
00003F00
// Capture length 16, generator length 4
00000010
00000004
// ADC ramp seeds
00001000
0000F000

// Waveform words
// a=0 b=0
00000000
// a=8000 b=-8000, both saturate
E0C01F40
// a=-100 b=100
0064FF9C
// a=-8192 b=8191
1FFFE000

// Expected DAC codes after offset and saturation
// a=256 b=-256
20FF1EFF
// a=8191 b=-8192
3FFF0000
// a=156 b=-156
209B1F63
// a=-7936 b=7935
01003EFF

/* sample_ram_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rp_consts.svh"

module sample_ram_arbiter (
  input  wire logic             adc_clk,
  input  wire logic             rst_n_i,
  input  wire rp_pkg::wb_req_t  host_req_i,
  input  wire rp_pkg::wb_req_t  cap_req_i,
  input  wire rp_pkg::wb_req_t  gen_req_i,
  output rp_pkg::wb_rsp_t       host_rsp_o,
  output rp_pkg::wb_rsp_t       cap_rsp_o,
  output rp_pkg::wb_rsp_t       gen_rsp_o
);

  localparam int NP = 3;           // Host, capture, generator

  logic [31:0]              mem [0:2**`RP_RAM_AW-1];
  rp_pkg::wb_req_t [NP-1:0] port;
  rp_pkg::wb_req_t          sel;   // Granted request
  logic [NP-1:0]            req;
  logic [NP-1:0]            gnt;
  logic [1:0]               gidx;
  logic [1:0]               ptr_q; // Highest priority port
  logic [NP-1:0]            ack_q;
  logic [31:0]              rdat_q;

  ////////////////////////////////////////////////////////////
  // Round-robin grant
  ////////////////////////////////////////////////////////////

  assign port = {gen_req_i, cap_req_i, host_req_i};

  // A port under ack still holds stb, it sits out one cycle
  always_comb
  begin
    for (int i = 0; i < NP; i++)
      req[i] = port[i].cyc & port[i].stb & ~ack_q[i];
  end

  // First requester at or after the pointer
  always_comb
  begin
    logic [1:0] k;
    gnt  = '0;
    gidx = '0;
    k    = ptr_q;
    for (int i = 0; i < NP; i++)
    begin
      if (gnt == '0 && req[k])
      begin
        gnt[k] = 1'b1;
        gidx   = k;
      end
      k = (k == 2'(NP - 1)) ? 2'd0 : k + 2'd1;
    end
  end

  assign sel = port[gidx];

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      ptr_q <= '0;
      ack_q <= '0;
    end
    else
    begin
      ack_q <= gnt;                  // Ack one cycle after grant
      if (|gnt)
        ptr_q <= (gidx == 2'(NP - 1)) ? 2'd0 : gidx + 2'd1;   // Winner goes last
    end
  end

  ////////////////////////////////////////////////////////////
  // Single port RAM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (|gnt)
    begin
      if (sel.we)
        mem[sel.adr[`RP_RAM_AW-1:0]] <= sel.dat;
      rdat_q <= mem[sel.adr[`RP_RAM_AW-1:0]];   // Old data on a write
    end
  end

  always_comb
  begin
    host_rsp_o = '{ack: ack_q[0], dat: rdat_q};
    cap_rsp_o  = '{ack: ack_q[1], dat: rdat_q};
    gen_rsp_o  = '{ack: ack_q[2], dat: rdat_q};
  end

  a_one_ack: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    $onehot0({host_rsp_o.ack, cap_rsp_o.ack, gen_rsp_o.ack}));

endmodule

`default_nettype wire

/* tb_analog_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rp_consts.svh"

module tb_analog_top;

  localparam int STIM_N    = 14;                  // Words in rp_stim.txt
  localparam int CYC_LIMIT = STIM_N * 16 + 3000;  // Run length bound

  logic                        adc_clk = 1'b0;
  logic                        rst_n_i;
  logic [1:0][`RP_ADC_W-1:0]   adc_dat = '0;
  rp_pkg::wb_req_t             wb_req;
  rp_pkg::wb_rsp_t             wb_rsp;
  rp_pkg::dac_pair_t           dac_dat;
  logic                        dac_wrt;
  logic [31:0]                 stim [0:STIM_N-1];
  int unsigned                 cyc_cnt = 0;
  int unsigned                 stb_cyc;         // Counter value at the last stb edge
  logic [31:0]                 loop_word [0:3];

  always #4 adc_clk = ~adc_clk;

  analog_top DUT (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .adc_dat_i (adc_dat),
    .wb_req_i  (wb_req ),
    .wb_rsp_o  (wb_rsp ),
    .dac_dat_o (dac_dat),
    .dac_wrt_o (dac_wrt)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Ramps, 4 LSB steps so the 14-bit sample moves each cycle
  function automatic logic [15:0] ramp_a(int unsigned c);
    return stim[4][15:0] + 16'(c * 4);
  endfunction

  function automatic logic [15:0] ramp_b(int unsigned c);
    return stim[5][15:0] - 16'(c * 4);
  endfunction

  // Top 14 bits, keep MSB and invert the rest, sign extend into a RAM word
  function automatic logic [31:0] adc_word(int unsigned c);
    logic [15:0] va;
    logic [15:0] vb;
    logic [13:0] ca;
    logic [13:0] cb;
    va = ramp_a(c);
    vb = ramp_b(c);
    ca = {va[15], ~va[14:2]};
    cb = {vb[15], ~vb[14:2]};
    return {{2{cb[13]}}, cb, {2{ca[13]}}, ca};
  endfunction

  function automatic rp_pkg::sample_t sat14(rp_pkg::sample_t x, rp_pkg::sample_t y);
    int s;
    s = int'(x) + int'(y);
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return 14'(s);
  endfunction

  task automatic fail_now(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic check_rd(input rp_pkg::wb_rsp_t got, input logic [31:0] exp,
                          input string what);
    if (got.dat !== exp)
      fail_now($sformatf("%s read 0x%08h, expected 0x%08h", what, got.dat, exp));
  endtask

  task automatic check_dac(input rp_pkg::dac_pair_t got, input rp_pkg::dac_pair_t exp,
                           input string what);
    if (got !== exp)
      fail_now($sformatf("%s DAC a=0x%04h b=0x%04h, expected a=0x%04h b=0x%04h",
                         what, got.a, got.b, exp.a, exp.b));
  endtask

  // One classic cycle, random idle gap before it
  task automatic wb_access(input logic we, input logic [9:0] adr, input logic [31:0] dat,
                           output rp_pkg::wb_rsp_t rsp);
    repeat ($urandom % 4) @(posedge adc_clk);
    @(posedge adc_clk);
    wb_req  <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    stb_cyc = cyc_cnt;
    do
      @(negedge adc_clk);  // Ack sampled mid cycle
    while (!wb_rsp.ack);
    rsp = wb_rsp;
    @(posedge adc_clk);
    wb_req <= '0;
  endtask

  task automatic wb_write(input logic [9:0] adr, input logic [31:0] dat);
    rp_pkg::wb_rsp_t rsp;
    wb_access(1'b1, adr, dat, rsp);
  endtask

  task automatic wb_read(input logic [9:0] adr, output rp_pkg::wb_rsp_t rsp);
    wb_access(1'b0, adr, 32'd0, rsp);
  endtask

  task automatic wb_read_expect(input logic [9:0] adr, input logic [31:0] exp,
                                input string what);
    rp_pkg::wb_rsp_t rsp;
    wb_read(adr, rsp);
    check_rd(rsp, exp, what);
  endtask

  task automatic wait_cap_done();
    rp_pkg::wb_rsp_t rsp;
    do
      wb_read(`RP_REG_STAT, rsp);
    while (!rsp.dat[0]);
  endtask

  // Free running counter, ADC ramp and run limit
  always @(posedge adc_clk)
  begin
    cyc_cnt    <= cyc_cnt + 1;
    adc_dat[0] <= ramp_a(cyc_cnt);
    adc_dat[1] <= ramp_b(cyc_cnt);
    if (cyc_cnt >= CYC_LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", CYC_LIMIT);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    rp_pkg::wb_rsp_t rsp;
    rp_pkg::sample_t sa;
    rp_pkg::sample_t sb;
    int unsigned     arm;
    int              idx;
    int              prev;
    rst_n_i = 1'b0;
    wb_req  = '0;
    void'($urandom(8));
    $readmemh("rp_stim.txt", stim);
    if ($isunknown(stim[STIM_N-1]))
      fail_now("stimulus file rp_stim.txt is missing or short");
    repeat (16) @(posedge adc_clk);
    rst_n_i <= 1'b1;

    // Reset state
    @(negedge adc_clk);
    if (wb_rsp.ack !== 1'b0 || dac_wrt !== 1'b0)
      fail_now("ack or dac_wrt not low after reset");
    check_dac(dac_dat, '{b: 14'h1FFF, a: 14'h1FFF}, "reset");

    // Register access
    wb_write(`RP_REG_OFS_A, stim[0]);
    wb_write(`RP_REG_OFS_B, stim[1]);
    wb_write(`RP_REG_CAP_LEN, stim[2]);
    wb_write(`RP_REG_GEN_LEN, stim[3]);
    wb_read_expect(`RP_REG_OFS_A, {{18{stim[0][13]}}, stim[0][13:0]}, "OFS_A");
    wb_read_expect(`RP_REG_OFS_B, {{18{stim[1][13]}}, stim[1][13:0]}, "OFS_B");
    wb_read_expect(`RP_REG_CAP_LEN, stim[2], "CAP_LEN");
    wb_read_expect(`RP_REG_GEN_LEN, stim[3], "GEN_LEN");
    wb_write(`RP_REG_CTRL, 32'h1);
    wb_read_expect(`RP_REG_CTRL, 32'h0, "CTRL arm");
    wait_cap_done();

    // Capture of the ramp, sample k from pin value at stb edge + 1 + 4k
    wb_write(`RP_REG_CTRL, 32'h1);
    arm = stb_cyc;
    wait_cap_done();
    for (int k = 0; k < 16; k++)
      wb_read_expect(10'(`RP_RAM_BASE + k), adc_word(arm + 1 + 4 * k),
                     $sformatf("capture word %0d", k));

    // Generation with offsets
    for (int k = 0; k < 4; k++)
      wb_write(10'(`RP_RAM_BASE + k), stim[6 + k]);
    wb_write(`RP_REG_CTRL, 32'h2);
    for (int n = 0; n < 8; n++)
    begin
      do
        @(negedge adc_clk);
      while (!dac_wrt);
      check_dac(dac_dat, '{b: stim[10 + n % 4][29:16], a: stim[10 + n % 4][13:0]},
                $sformatf("generator write %0d", n));
    end

    // Digital loop, same offsets and a 16 word table of the 4 entry cycle
    for (int k = 4; k < 16; k++)
      wb_write(10'(`RP_RAM_BASE + k), stim[6 + k % 4]);
    wb_write(`RP_REG_GEN_LEN, 32'd16);
    wb_write(`RP_REG_CTRL, 32'h0);
    for (int k = 0; k < 4; k++)
    begin
      sa           = sat14(stim[6 + k][13:0], stim[0][13:0]);
      sb           = sat14(stim[6 + k][29:16], stim[1][13:0]);
      loop_word[k] = {{2{sb[13]}}, sb, {2{sa[13]}}, sa};   // Saturated pair as a RAM word
    end
    wb_write(`RP_REG_CTRL, 32'h7);
    wait_cap_done();
    prev = -1;
    for (int k = 0; k < 16; k++)
    begin
      wb_read(10'(`RP_RAM_BASE + k), rsp);
      idx = -1;
      for (int i = 0; i < 4; i++)
        if (rsp.dat === loop_word[i])
          idx = i;
      if (idx < 0)
        fail_now($sformatf("loop word %0d = 0x%08h not in generator sequence", k, rsp.dat));
      // Word 0 holds the sample from before the restart
      if (k >= 2 && idx != (prev + 1) % 4)
        fail_now($sformatf("loop word %0d out of cyclic order", k));
      prev = idx;
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
rp_pkg.sv
adc_frontend.sv
capture_writer.sv
waveform_reader.sv
sample_ram_arbiter.sv
dac_backend.sv
host_regs.sv
analog_top.sv
tb_analog_top.sv

/* waveform_reader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rp_consts.svh"

module waveform_reader (
  input  wire logic                  adc_clk,
  input  wire logic                  rst_n_i,
  input  wire logic                  gen_en_i,
  input  wire logic [`RP_RAM_AW:0]   gen_len_i,
  output rp_pkg::wb_req_t            mem_req_o,
  input  wire rp_pkg::wb_rsp_t       mem_rsp_i,
  output rp_pkg::sample_pair_t       smp_o,
  output logic                       smp_vld_o
);

  localparam int PW = $clog2(`RP_DECIM);
  localparam int SW = `RP_SMP_W;

  logic [PW-1:0]       pace_q;
  logic [`RP_RAM_AW:0] ptr_q;     // Next read address
  logic [`RP_RAM_AW:0] ptr_nxt;
  logic [`RP_RAM_AW:0] adr_q;     // Address of the pending read
  logic                stb_q;
  logic                issue;

  assign issue   = gen_en_i && pace_q == '0 && gen_len_i != '0;
  assign ptr_nxt = ptr_q + 1'b1;

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      pace_q    <= '0;
      ptr_q     <= '0;
      stb_q     <= 1'b0;
      smp_vld_o <= 1'b0;
    end
    else
    begin
      smp_vld_o <= mem_rsp_i.ack;     // One pulse per returned word
      if (mem_rsp_i.ack)
        stb_q <= 1'b0;
      if (!gen_en_i)
      begin
        pace_q <= '0;                 // Restart from address 0
        ptr_q  <= '0;
      end
      else
      begin
        pace_q <= (pace_q == PW'(`RP_DECIM - 1)) ? '0 : pace_q + 1'b1;
        if (issue)
        begin
          stb_q <= 1'b1;
          ptr_q <= (ptr_nxt >= gen_len_i) ? '0 : ptr_nxt;   // Cyclic wrap
        end
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (issue)
      adr_q <= ptr_q;
  end

  // Unpack low 14 bits of each half word
  always_ff @(posedge adc_clk)
  begin
    if (mem_rsp_i.ack)
    begin
      smp_o.a <= mem_rsp_i.dat[SW-1:0];
      smp_o.b <= mem_rsp_i.dat[16 +: SW];
    end
  end

  always_comb
  begin
    mem_req_o.cyc = stb_q;
    mem_req_o.stb = stb_q;
    mem_req_o.we  = 1'b0;       // Read only
    mem_req_o.adr = {{(`RP_WB_AW-`RP_RAM_AW){1'b0}}, adr_q[`RP_RAM_AW-1:0]};
    mem_req_o.dat = '0;
  end

endmodule

`default_nettype wire
